//--- pipe_core.f
+incdir+design
design/pipe_core_pkg.sv
design/reg_file.sv
design/operand_bypass.sv
design/decode_stage.sv
design/alu_execute.sv
design/writeback_stage.sv
design/pipe_core_top.sv
test/pipe_core_assertions.sv
test/tb_pipe_core.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_pipe_core -f pipe_core.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_pipe_core > sim.log 2>&1
cat sim.log

grep -qx "RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/tb_pipe_core.sv
`timescale 1ns/1ps
`include "pipe_core_params.svh"

module tb_pipe_core;
    import pipe_core_pkg::*;

    localparam int NUM_INST       = 2000;
    localparam int NUM_FULL       = 600;
    localparam int NUM_SINGLE     = 50;
    localparam int NUM_RANDOM     = NUM_INST - NUM_FULL - NUM_SINGLE;
    localparam int TIMEOUT_CYCLES = 8 * NUM_INST + 200;
    // edges from the accepting edge up to the one that raises commit_valid
    localparam int LATENCY        = 3;

    logic                      clk;
    logic                      arst_n;
    logic                      in_valid;
    inst_u                     in_inst;
    logic                      in_ready;
    logic                      commit_valid;
    logic                      commit_ready;
    res_t                      commit;
    logic [`PC_REG_IDX_W-1:0]  dbg_reg_num;
    logic [`PC_DATA_W-1:0]     dbg_reg_data;

    integer                    seed;
    int                        cycles;
    logic [`PC_DATA_W-1:0]     model_regs [0:`PC_REG_NUM-1];
    // accepted words, oldest first
    logic [`PC_DATA_W-1:0]     pending [$];

    pipe_core_top DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .in_ready    (in_ready),
        .commit_valid(commit_valid),
        .commit_ready(commit_ready),
        .commit      (commit),
        .dbg_reg_num (dbg_reg_num),
        .dbg_reg_data(dbg_reg_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (want !== got) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, want, got);
            abort_run("value mismatch");
        end
    endtask

    // reference semantics straight from the instruction format
    function automatic res_t model_result(input logic [31:0] inst);
        res_t        r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        known;
        imm   = {{14{inst[31]}}, inst[31:14]};
        a     = model_regs[inst[13:9]];
        b     = inst[3] ? imm : model_regs[inst[18:14]];
        known = 1'b1;
        case (inst[3:0])
            4'd0, 4'd8:  r.data = a + b;
            4'd1:        r.data = a - b;
            4'd2, 4'd9:  r.data = a & b;
            4'd3, 4'd10: r.data = a | b;
            4'd4:        r.data = a ^ b;
            default: begin
                r.data = '0;
                known  = 1'b0;
            end
        endcase
        r.inst = inst;
        r.rd   = inst[8:4];
        r.wen  = known && (inst[8:4] != 5'd0);
        return r;
    endfunction

    task automatic check_commit();
        res_t want;
        if (pending.size() == 0) begin
            abort_run("commit seen with no instruction outstanding");
        end else begin
            want = model_result(pending.pop_front());
            check_value("commit.inst", want.inst, commit.inst);
            check_value("commit.rd", {27'd0, want.rd}, {27'd0, commit.rd});
            check_value("commit.wen", {31'd0, want.wen}, {31'd0, commit.wen});
            check_value("commit.data", want.data, commit.data);
            // model state advances in commit order
            if (want.wen) begin
                model_regs[want.rd] = want.data;
            end
        end
    endtask

    // one cycle: drive on the falling edge, settle, account for the coming edge
    task automatic step(input logic v, input logic [31:0] inst, input logic cr,
                        output logic took, output logic seen);
        @(negedge clk);
        in_valid     = v;
        in_inst      = inst_u'(inst);
        commit_ready = cr;
        #1;
        seen = commit_valid;
        if (commit_valid && commit_ready) begin
            check_commit();
        end
        took = v && in_ready;
        if (took) begin
            pending.push_back(inst);
        end
    endtask

    task automatic make_inst(output logic [31:0] inst);
        logic [31:0] r;
        inst = $random(seed);
        r    = $random(seed);
        // roughly one in eight keeps a raw opcode, often undefined
        if (r[2:0] != 3'd0) begin
            case (r[5:3])
                3'd0:    inst[3:0] = 4'd0;
                3'd1:    inst[3:0] = 4'd1;
                3'd2:    inst[3:0] = 4'd2;
                3'd3:    inst[3:0] = 4'd3;
                3'd4:    inst[3:0] = 4'd4;
                3'd5:    inst[3:0] = 4'd8;
                3'd6:    inst[3:0] = 4'd9;
                default: inst[3:0] = 4'd10;
            endcase
        end
        // narrow register range forces back-to-back hazards
        if (r[9:6] != 4'd0) begin
            inst[8:4]   = {3'd0, r[11:10]};
            inst[13:9]  = {3'd0, r[13:12]};
            inst[18:14] = {3'd0, r[15:14]};
        end
    endtask

    // hold the word until accepted, ready drawn fresh each cycle
    task automatic feed(input logic [31:0] inst, input logic random_ready);
        logic        took;
        logic        seen;
        logic        cr;
        logic [31:0] r;
        took = 1'b0;
        while (!took) begin
            r  = $random(seed);
            cr = !random_ready || (r[2:0] > 3'd2);
            step(1'b1, inst, cr, took, seen);
        end
    endtask

    task automatic drain();
        logic took;
        logic seen;
        while (pending.size() != 0) begin
            step(1'b0, 32'd0, 1'b1, took, seen);
        end
        // last commit lands on the next edge
        step(1'b0, 32'd0, 1'b1, took, seen);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        abort_run("timeout: instructions did not all commit in time");
    end

    initial begin
        logic [31:0] inst;
        logic [31:0] r;
        logic        took;
        logic        seen;
        int          edges;
        seed         = 64797;
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        in_inst      = '0;
        commit_ready = 1'b0;
        dbg_reg_num  = '0;
        for (int i = 0; i < `PC_REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        check_value("commit_valid", 32'd0, {31'd0, commit_valid});
        check_value("in_ready", 32'd1, {31'd0, in_ready});

        // full rate, dependent words back to back
        for (int n = 0; n < NUM_FULL; n++) begin
            make_inst(inst);
            feed(inst, 1'b0);
        end

        // random back-pressure and input gaps
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = $random(seed);
            if (r[1:0] == 2'd0) begin
                step(1'b0, 32'd0, r[2], took, seen);
            end
            make_inst(inst);
            feed(inst, 1'b1);
        end
        drain();

        // isolated words for latency
        for (int n = 0; n < NUM_SINGLE; n++) begin
            make_inst(inst);
            feed(inst, 1'b0);
            edges = 0;
            seen  = 1'b0;
            while (!seen && (edges < 8)) begin
                step(1'b0, 32'd0, 1'b1, took, seen);
                edges++;
            end
            check_value("commit latency", LATENCY, edges);
        end
        drain();

        // debug port sweep against model
        for (int i = 0; i < `PC_REG_NUM; i++) begin
            @(negedge clk);
            dbg_reg_num = i[`PC_REG_IDX_W-1:0];
            #1;
            check_value("dbg_reg_data", model_regs[i], dbg_reg_data);
        end
        @(negedge clk);
        dbg_reg_num = '0;
        #1;
        check_value("dbg_reg_data r0", 32'd0, dbg_reg_data);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- test/pipe_core_assertions.sv
`timescale 1ns/1ps

module pipe_core_assertions (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  in_valid,
    input logic                  in_ready,
    input pipe_core_pkg::inst_u  in_inst,
    input logic                  commit_valid,
    input logic                  commit_ready,
    input pipe_core_pkg::res_t   commit
);
    // stalled input keeps its word
    a_in_stable: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_inst))
        else $error("input word changed while stalled");

    // stalled commit record frozen
    a_commit_stable: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else $error("commit record changed while stalled");

    a_commit_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(commit_valid))
        else $error("commit_valid unknown out of reset");

    // r0 writes are dropped at decode
    a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid |-> !(commit.wen && (commit.rd == '0)))
        else $error("commit writes register 0");

endmodule

bind pipe_core_top pipe_core_assertions u_assertions (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_inst     (in_inst),
    .commit_valid(commit_valid),
    .commit_ready(commit_ready),
    .commit      (commit)
);

//--- design/pipe_core_top.sv
`timescale 1ns/1ps
`include "pipe_core_params.svh"

module pipe_core_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  pipe_core_pkg::inst_u      in_inst,
    output logic                      in_ready,
    output logic                      commit_valid,
    input  logic                      commit_ready,
    output pipe_core_pkg::res_t       commit,
    input  logic [`PC_REG_IDX_W-1:0]  dbg_reg_num,
    output logic [`PC_DATA_W-1:0]     dbg_reg_data
);
    import pipe_core_pkg::*;

    // decode to execute link
    logic                      dec_valid;
    logic                      dec_ready;
    dec_t                      dec;

    // execute to writeback link
    logic                      ex_valid;
    logic                      ex_ready;
    res_t                      ex;

    // operand read path
    logic [`PC_REG_IDX_W-1:0]  rs1_idx;
    logic [`PC_REG_IDX_W-1:0]  rs2_idx;
    logic [`PC_DATA_W-1:0]     rs1_raw;
    logic [`PC_DATA_W-1:0]     rs2_raw;
    logic [`PC_DATA_W-1:0]     rs1_data;
    logic [`PC_DATA_W-1:0]     rs2_data;
    fwd_t                      ex_fwd;
    fwd_t                      wb_fwd;

    // register file write from commit
    logic                      rf_wen;
    logic [`PC_REG_IDX_W-1:0]  rf_widx;
    logic [`PC_DATA_W-1:0]     rf_wdata;

    decode_stage u_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_inst  (in_inst),
        .in_ready (in_ready),
        .dec_valid(dec_valid),
        .dec_ready(dec_ready),
        .dec      (dec),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx)
    );

    reg_file u_rf (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .dbg_idx (dbg_reg_num),
        .rf_wen  (rf_wen),
        .rf_widx (rf_widx),
        .rf_wdata(rf_wdata),
        .rs1_raw (rs1_raw),
        .rs2_raw (rs2_raw),
        .dbg_data(dbg_reg_data)
    );

    operand_bypass u_bypass (
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_raw (rs1_raw),
        .rs2_raw (rs2_raw),
        .ex_fwd  (ex_fwd),
        .wb_fwd  (wb_fwd),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    alu_execute u_execute (
        .clk      (clk),
        .arst_n   (arst_n),
        .dec_valid(dec_valid),
        .dec_ready(dec_ready),
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ex_valid (ex_valid),
        .ex_ready (ex_ready),
        .ex       (ex),
        .ex_fwd   (ex_fwd)
    );

    writeback_stage u_writeback (
        .clk         (clk),
        .arst_n      (arst_n),
        .ex_valid    (ex_valid),
        .ex_ready    (ex_ready),
        .ex          (ex),
        .commit_valid(commit_valid),
        .commit_ready(commit_ready),
        .commit      (commit),
        .wb_fwd      (wb_fwd),
        .rf_wen      (rf_wen),
        .rf_widx     (rf_widx),
        .rf_wdata    (rf_wdata)
    );

endmodule

//--- design/writeback_stage.sv
`timescale 1ns/1ps
`include "pipe_core_params.svh"

module writeback_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      ex_valid,
    output logic                      ex_ready,
    input  pipe_core_pkg::res_t       ex,
    output logic                      commit_valid,
    input  logic                      commit_ready,
    output pipe_core_pkg::res_t       commit,
    output pipe_core_pkg::fwd_t       wb_fwd,
    output logic                      rf_wen,
    output logic [`PC_REG_IDX_W-1:0]  rf_widx,
    output logic [`PC_DATA_W-1:0]     rf_wdata
);
    import pipe_core_pkg::*;

    logic commit_fire;

    assign ex_ready    = !commit_valid || commit_ready;
    assign commit_fire = commit_valid && commit_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid <= 1'b0;
        end else if (ex_ready) begin
            commit_valid <= ex_valid;
        end
    end

    // commit record, stable under back-pressure
    always_ff @(posedge clk) begin
        if (ex_valid && ex_ready) begin
            commit <= ex;
        end
    end

    // forward while held, rf takes it only on commit
    assign wb_fwd.valid = commit_valid && commit.wen;
    assign wb_fwd.rd    = commit.rd;
    assign wb_fwd.data  = commit.data;

    assign rf_wen   = commit_fire && commit.wen;
    assign rf_widx  = commit.rd;
    assign rf_wdata = commit.data;

endmodule

//--- design/alu_execute.sv
`timescale 1ns/1ps
`include "pipe_core_params.svh"

module alu_execute (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      dec_valid,
    output logic                      dec_ready,
    input  pipe_core_pkg::dec_t       dec,
    input  logic [`PC_DATA_W-1:0]     rs1_data,
    input  logic [`PC_DATA_W-1:0]     rs2_data,
    output logic                      ex_valid,
    input  logic                      ex_ready,
    output pipe_core_pkg::res_t       ex,
    output pipe_core_pkg::fwd_t       ex_fwd
);
    import pipe_core_pkg::*;

    logic [`PC_DATA_W-1:0] op_b;
    logic [`PC_DATA_W-1:0] alu_res;
    logic                  accept;

    assign dec_ready = !ex_valid || ex_ready;
    assign accept    = dec_valid && dec_ready;

    // immediate replaces rs2 for I-type
    assign op_b = dec.is_i ? dec.imm : rs2_data;

    always_comb begin
        case (dec.opc)
            OP_ADD, OP_ADDI: alu_res = rs1_data + op_b;
            OP_SUB:          alu_res = rs1_data - op_b;
            OP_AND, OP_ANDI: alu_res = rs1_data & op_b;
            OP_OR,  OP_ORI:  alu_res = rs1_data | op_b;
            OP_XOR:          alu_res = rs1_data ^ op_b;
            // no-op result
            default:         alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else if (dec_ready) begin
            ex_valid <= dec_valid;
        end
    end

    // result register
    always_ff @(posedge clk) begin
        if (accept) begin
            ex.inst <= dec.inst;
            ex.rd   <= dec.rd;
            ex.wen  <= dec.wen;
            ex.data <= alu_res;
        end
    end

    // forward straight from the held register
    assign ex_fwd.valid = ex_valid && ex.wen;
    assign ex_fwd.rd    = ex.rd;
    assign ex_fwd.data  = ex.data;

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps
`include "pipe_core_params.svh"

module decode_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  pipe_core_pkg::inst_u      in_inst,
    output logic                      in_ready,
    output logic                      dec_valid,
    input  logic                      dec_ready,
    output pipe_core_pkg::dec_t       dec,
    output logic [`PC_REG_IDX_W-1:0]  rs1_idx,
    output logic [`PC_REG_IDX_W-1:0]  rs2_idx
);
    import pipe_core_pkg::*;

    dec_t dec_next;
    logic defined;
    logic accept;

    // empty, or draining into execute this cycle
    assign in_ready = !dec_valid || dec_ready;
    assign accept   = in_valid && in_ready;

    // opcode outside the table commits as a no-op
    always_comb begin
        case (in_inst.r.opc)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_ADDI, OP_ANDI, OP_ORI: defined = 1'b1;
            default: defined = 1'b0;
        endcase
    end

    always_comb begin
        dec_next.inst = in_inst;
        dec_next.opc  = opcode_e'(in_inst.r.opc);
        dec_next.rd   = in_inst.r.rd;
        dec_next.rs1  = in_inst.r.rs1;
        // opcode bit 3 picks the I view
        dec_next.is_i = in_inst.r.opc[`PC_OPC_W-1];
        // I-type has no rs2, those bits are immediate
        if (dec_next.is_i) begin
            dec_next.rs2 = '0;
            dec_next.imm = {{(`PC_DATA_W-`PC_IMM_W){in_inst.i.imm[`PC_IMM_W-1]}},
                            in_inst.i.imm};
        end else begin
            dec_next.rs2 = in_inst.r.rs2;
            dec_next.imm = '0;
        end
        // writes to r0 dropped here, bypass relies on it
        dec_next.wen  = defined && (in_inst.r.rd != '0);
    end

    // stage valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    // decoded payload, held while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            dec <= dec_next;
        end
    end

    // indices come from the held register
    // so forwarding keeps tracking younger results during a stall
    assign rs1_idx = dec.rs1;
    assign rs2_idx = dec.rs2;

endmodule

//--- design/operand_bypass.sv
`timescale 1ns/1ps
`include "pipe_core_params.svh"

module operand_bypass (
    input  logic [`PC_REG_IDX_W-1:0]  rs1_idx,
    input  logic [`PC_REG_IDX_W-1:0]  rs2_idx,
    input  logic [`PC_DATA_W-1:0]     rs1_raw,
    input  logic [`PC_DATA_W-1:0]     rs2_raw,
    input  pipe_core_pkg::fwd_t       ex_fwd,
    input  pipe_core_pkg::fwd_t       wb_fwd,
    output logic [`PC_DATA_W-1:0]     rs1_data,
    output logic [`PC_DATA_W-1:0]     rs2_data
);
    import pipe_core_pkg::*;

    // youngest match wins, execute is one step younger than writeback
    // rd=0 never arrives with valid set, decode clears its write flag
    function automatic logic [`PC_DATA_W-1:0] pick(
        input logic [`PC_REG_IDX_W-1:0] idx,
        input logic [`PC_DATA_W-1:0]    raw
    );
        logic [`PC_DATA_W-1:0] val;
        val = raw;
        if (wb_fwd.valid && (wb_fwd.rd == idx)) begin
            val = wb_fwd.data;
        end
        if (ex_fwd.valid && (ex_fwd.rd == idx)) begin
            val = ex_fwd.data;
        end
        return val;
    endfunction

    // wb source also covers the write landing this edge
    assign rs1_data = pick(rs1_idx, rs1_raw);
    assign rs2_data = pick(rs2_idx, rs2_raw);

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps
`include "pipe_core_params.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`PC_REG_IDX_W-1:0]  rs1_idx,
    input  logic [`PC_REG_IDX_W-1:0]  rs2_idx,
    input  logic [`PC_REG_IDX_W-1:0]  dbg_idx,
    input  logic                      rf_wen,
    input  logic [`PC_REG_IDX_W-1:0]  rf_widx,
    input  logic [`PC_DATA_W-1:0]     rf_wdata,
    output logic [`PC_DATA_W-1:0]     rs1_raw,
    output logic [`PC_DATA_W-1:0]     rs2_raw,
    output logic [`PC_DATA_W-1:0]     dbg_data
);
    // storage for r1..r31 only, r0 has no entry
    logic [`PC_DATA_W-1:0] regs [1:`PC_REG_NUM-1];

    // r0 hardwired to zero on every read port
    function automatic logic [`PC_DATA_W-1:0] rd_port(input logic [`PC_REG_IDX_W-1:0] idx);
        return (idx == '0) ? '0 : regs[idx];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `PC_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wen && (rf_widx != '0)) begin
            regs[rf_widx] <= rf_wdata;
        end
    end

    // three async read ports
    assign rs1_raw  = rd_port(rs1_idx);
    assign rs2_raw  = rd_port(rs2_idx);
    assign dbg_data = rd_port(dbg_idx);

endmodule

//--- design/pipe_core_pkg.sv
`include "pipe_core_params.svh"

package pipe_core_pkg;

    // defined opcodes, bit 3 marks I-type
    typedef enum logic [`PC_OPC_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDI = 4'd8,
        OP_ANDI = 4'd9,
        OP_ORI  = 4'd10
    } opcode_e;

    // R-type view, bits 31..19 unused
    typedef struct packed {
        logic [12:0]               unused;
        logic [`PC_REG_IDX_W-1:0]  rs2;
        logic [`PC_REG_IDX_W-1:0]  rs1;
        logic [`PC_REG_IDX_W-1:0]  rd;
        logic [`PC_OPC_W-1:0]      opc;
    } r_fields_t;

    // I-type view, rs2 bits reused as low immediate bits
    typedef struct packed {
        logic [`PC_IMM_W-1:0]      imm;
        logic [`PC_REG_IDX_W-1:0]  rs1;
        logic [`PC_REG_IDX_W-1:0]  rd;
        logic [`PC_OPC_W-1:0]      opc;
    } i_fields_t;

    // one instruction word, two decodings
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

    // decode register contents
    typedef struct packed {
        logic [`PC_DATA_W-1:0]     inst;
        logic [`PC_REG_IDX_W-1:0]  rs1;
        logic [`PC_REG_IDX_W-1:0]  rs2;
        logic [`PC_REG_IDX_W-1:0]  rd;
        logic                      wen;
        logic                      is_i;
        logic [`PC_DATA_W-1:0]     imm;
        opcode_e                   opc;
    } dec_t;

    // one computed result, also the commit record
    typedef struct packed {
        logic [`PC_DATA_W-1:0]     inst;
        logic [`PC_REG_IDX_W-1:0]  rd;
        logic                      wen;
        logic [`PC_DATA_W-1:0]     data;
    } res_t;

    // forwarding source seen by the bypass
    typedef struct packed {
        logic                      valid;
        logic [`PC_REG_IDX_W-1:0]  rd;
        logic [`PC_DATA_W-1:0]     data;
    } fwd_t;

endpackage

//--- design/pipe_core_params.svh
`ifndef PIPE_CORE_PARAMS_SVH
`define PIPE_CORE_PARAMS_SVH

// datapath and instruction word width
`define PC_DATA_W 32

// architectural register count
`define PC_REG_NUM 32

// register index width, log2 of PC_REG_NUM
`define PC_REG_IDX_W 5

// opcode field, low bits of the word
`define PC_OPC_W 4

// signed immediate of the I-type view
`define PC_IMM_W 18

`endif
